// ==== graph_kernel_pkg.sv ====
// Graph kernel front end shared definitions
// Widths, vector types, queue sizing and the FSM state encodings
`default_nettype none

package graph_kernel_pkg;

  // ------------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------------
  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 32;
  localparam int COUNT_W = 8;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [COUNT_W-1:0] count_t;
  // Sum of response words, wraps at 2**DATA_W
  typedef logic [DATA_W-1:0]  checksum_t;

  // ------------------------------------------------------------------------
  // Memory and queue sizing
  // ------------------------------------------------------------------------
  // One cache line per read
  localparam int LINE_BYTES        = 64;
  localparam int QUEUE_DEPTH       = 16;
  localparam int QUEUE_INIT_CYCLES = 8;

  // Counter for the post-reset busy window
  localparam int INIT_CNT_W = $clog2(QUEUE_INIT_CYCLES + 1);
  // In-flight request counter, must reach QUEUE_DEPTH
  localparam int CREDIT_W   = $clog2(QUEUE_DEPTH + 1);

  // ------------------------------------------------------------------------
  // State machines
  // ------------------------------------------------------------------------
  typedef enum logic [2:0] {
    ctl_idle,
    ctl_setup_wait,
    ctl_start,
    ctl_busy,
    ctl_done
  } control_state_t;

  typedef enum logic [1:0] {
    gen_idle,
    gen_run,
    gen_drain
  } gen_state_t;

endpackage

`default_nettype wire

// ==== sync_fifo.sv ====
// Synchronous FIFO with first-word fall-through head
// Reports busy for a fixed window after reset and drops writes meanwhile
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 16
) (
  input  logic             ap_clk,
  input  logic             control_areset,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] din,
  input  logic             rd_en,
  output logic [WIDTH-1:0] dout,
  output logic             full,
  output logic             empty,
  output logic             busy
);
  import graph_kernel_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0]      mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;
  logic [INIT_CNT_W-1:0] init_cnt;
  logic                  do_write;
  logic                  do_read;

  // Pointer advance, wraps for any depth
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Status flags
  assign busy  = (init_cnt != INIT_CNT_W'(QUEUE_INIT_CYCLES));
  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);

  // Writes dropped while full or still initialising
  assign do_write = wr_en && !full && !busy;
  assign do_read  = rd_en && !empty;

  // Head always visible
  assign dout = mem[rd_ptr];

  // ------------------------------------------------------------------------
  // Post-reset busy window
  // ------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      init_cnt <= '0;
    end else if (busy) begin
      init_cnt <= init_cnt + 1'b1;
    end
  end

  // ------------------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_read) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge ap_clk) begin
    if (do_write) begin
      mem[wr_ptr] <= din;
    end
  end

endmodule

`default_nettype wire

// ==== kernel_control.sv ====
// Kernel control block
// Registers host inputs, sequences start/ready/done/continue
// and hands the captured descriptor to the setup generator
`timescale 1ns/1ps
`default_nettype none

module kernel_control (
  input  logic                        ap_clk,
  input  logic                        control_areset,
  input  logic                        ap_start,
  input  logic                        ap_continue,
  input  logic                        descriptor_valid,
  input  graph_kernel_pkg::addr_t     descriptor_base_addr,
  input  graph_kernel_pkg::count_t    descriptor_num_reads,
  input  logic                        req_queue_busy,
  input  logic                        resp_queue_busy,
  input  logic                        job_complete,
  input  graph_kernel_pkg::checksum_t job_checksum,
  output logic                        ap_ready,
  output logic                        ap_idle,
  output logic                        ap_done,
  output graph_kernel_pkg::checksum_t result_checksum,
  output logic                        job_start,
  output graph_kernel_pkg::addr_t     job_base_addr,
  output graph_kernel_pkg::count_t    job_num_reads
);
  import graph_kernel_pkg::*;

  control_state_t state;

  // Registered host inputs
  logic   start_reg;
  logic   continue_reg;
  logic   desc_valid_reg;
  addr_t  desc_base_reg;
  count_t desc_num_reg;

  // Setup readiness from queue reset-busy flags
  logic   queue_busy_reg;
  logic   setup_ready;

  assign setup_ready = ~queue_busy_reg;

  // ------------------------------------------------------------------------
  // Input stage
  // ------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      start_reg      <= 1'b0;
      continue_reg   <= 1'b0;
      desc_valid_reg <= 1'b0;
      // Queues count as busy until proven otherwise
      queue_busy_reg <= 1'b1;
    end else begin
      start_reg      <= ap_start;
      continue_reg   <= ap_continue;
      desc_valid_reg <= descriptor_valid;
      queue_busy_reg <= req_queue_busy | resp_queue_busy;
    end
  end

  // Descriptor payload
  always_ff @(posedge ap_clk) begin
    desc_base_reg <= descriptor_base_addr;
    desc_num_reg  <= descriptor_num_reads;
  end

  // ------------------------------------------------------------------------
  // Control FSM with registered outputs
  // ------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      state     <= ctl_idle;
      ap_ready  <= 1'b0;
      ap_idle   <= 1'b1;
      ap_done   <= 1'b0;
      job_start <= 1'b0;
    end else begin
      // Single-cycle pulses by default
      ap_ready  <= 1'b0;
      job_start <= 1'b0;
      case (state)
        ctl_idle: begin
          if (start_reg) begin
            state <= ctl_setup_wait;
          end
        end
        ctl_setup_wait: begin
          // Host dropped start before queues came up
          if (!start_reg) begin
            state <= ctl_idle;
          end else if (setup_ready) begin
            ap_ready <= 1'b1;
            ap_idle  <= 1'b0;
            state    <= ctl_start;
          end
        end
        ctl_start: begin
          // First descriptor after ready launches the job
          if (desc_valid_reg) begin
            job_start <= 1'b1;
            state     <= ctl_busy;
          end
        end
        ctl_busy: begin
          if (job_complete) begin
            ap_done <= 1'b1;
            state   <= ctl_done;
          end
        end
        ctl_done: begin
          // Done held until host acknowledges
          if (continue_reg) begin
            ap_done <= 1'b0;
            ap_idle <= 1'b1;
            state   <= ctl_idle;
          end
        end
        default: state <= ctl_idle;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // Job descriptor and result capture
  // ------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (state == ctl_start && desc_valid_reg) begin
      job_base_addr <= desc_base_reg;
      job_num_reads <= desc_num_reg;
    end
    if (state == ctl_busy && job_complete) begin
      result_checksum <= job_checksum;
    end
  end

endmodule

`default_nettype wire

// ==== setup_request_gen.sv ====
// Setup request generator
// Issues one read per cache line of the job, bounded by a credit count,
// and sums the returned words into the job checksum
`timescale 1ns/1ps
`default_nettype none

module setup_request_gen (
  input  logic                        ap_clk,
  input  logic                        control_areset,
  input  logic                        job_start,
  input  graph_kernel_pkg::addr_t     job_base_addr,
  input  graph_kernel_pkg::count_t    job_num_reads,
  input  logic                        req_full,
  output logic                        req_push,
  output graph_kernel_pkg::addr_t     req_addr,
  input  logic                        resp_empty,
  output logic                        resp_pop,
  input  graph_kernel_pkg::data_t     resp_data,
  output logic                        job_complete,
  output graph_kernel_pkg::checksum_t job_checksum
);
  import graph_kernel_pkg::*;

  gen_state_t state;

  // Address of the next read
  addr_t     next_addr;
  // Reads still to issue
  count_t    issue_left;
  // Responses still to collect
  count_t    resp_left;
  // Pushed but not yet popped
  logic [CREDIT_W-1:0] outstanding;
  checksum_t checksum;
  logic      credit_ok;

  // ------------------------------------------------------------------------
  // Queue handshakes
  // ------------------------------------------------------------------------
  // Credit cap keeps the response queue from overflowing
  assign credit_ok = (outstanding != CREDIT_W'(QUEUE_DEPTH));

  assign req_push = (state == gen_run) && (issue_left != '0) && !req_full && credit_ok;
  assign req_addr = next_addr;

  // Responses drained whenever a job is active
  assign resp_pop = (state != gen_idle) && !resp_empty;

  assign job_checksum = checksum;

  // ------------------------------------------------------------------------
  // Sequencing and counters
  // ------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      state        <= gen_idle;
      issue_left   <= '0;
      resp_left    <= '0;
      outstanding  <= '0;
      job_complete <= 1'b0;
    end else begin
      job_complete <= 1'b0;

      case ({req_push, resp_pop})
        2'b10:   outstanding <= outstanding + 1'b1;
        2'b01:   outstanding <= outstanding - 1'b1;
        default: outstanding <= outstanding;
      endcase

      if (req_push) begin
        issue_left <= issue_left - 1'b1;
      end
      if (resp_pop) begin
        resp_left <= resp_left - 1'b1;
      end

      case (state)
        gen_idle: begin
          if (job_start) begin
            issue_left <= job_num_reads;
            resp_left  <= job_num_reads;
            // Empty job finishes straight away
            if (job_num_reads == '0) begin
              job_complete <= 1'b1;
            end else begin
              state <= gen_run;
            end
          end
        end
        gen_run: begin
          // Last request issued
          if (req_push && issue_left == count_t'(1)) begin
            state <= gen_drain;
          end
        end
        gen_drain: begin
          if (resp_pop && resp_left == count_t'(1)) begin
            job_complete <= 1'b1;
            state        <= gen_idle;
          end
        end
        default: state <= gen_idle;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // Address walk and checksum
  // ------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (state == gen_idle && job_start) begin
      next_addr <= job_base_addr;
      checksum  <= '0;
    end else begin
      if (req_push) begin
        next_addr <= next_addr + addr_t'(LINE_BYTES);
      end
      // Wraps modulo 2**DATA_W
      if (resp_pop) begin
        checksum <= checksum + resp_data;
      end
    end
  end

endmodule

`default_nettype wire

// ==== graph_kernel_top.sv ====
// Graph kernel front end top level
// Control block, setup request generator and the two memory-side queues
`timescale 1ns/1ps
`default_nettype none

module graph_kernel_top (
  input  logic                        ap_clk,
  input  logic                        control_areset,
  // Host control
  input  logic                        ap_start,
  input  logic                        ap_continue,
  input  logic                        descriptor_valid,
  input  graph_kernel_pkg::addr_t     descriptor_base_addr,
  input  graph_kernel_pkg::count_t    descriptor_num_reads,
  output logic                        ap_ready,
  output logic                        ap_idle,
  output logic                        ap_done,
  output graph_kernel_pkg::checksum_t result_checksum,
  // Memory requests
  output logic                        mem_req_valid,
  output graph_kernel_pkg::addr_t     mem_req_addr,
  input  logic                        mem_req_ready,
  // Memory responses
  input  logic                        mem_resp_valid,
  input  graph_kernel_pkg::data_t     mem_resp_data
);
  import graph_kernel_pkg::*;

  // Control to generator
  logic      job_start;
  addr_t     job_base_addr;
  count_t    job_num_reads;
  logic      job_complete;
  checksum_t job_checksum;

  // Request queue
  logic      req_push;
  addr_t     req_addr;
  logic      req_full;
  logic      req_empty;
  logic      req_busy;

  // Response queue
  logic      resp_pop;
  data_t     resp_data;
  logic      resp_empty;
  logic      resp_busy;

  // Memory sees the queue head whenever it holds anything
  assign mem_req_valid = ~req_empty;

  // ------------------------------------------------------------------------
  // Control
  // ------------------------------------------------------------------------
  kernel_control control0 (
    .ap_clk               (ap_clk),
    .control_areset       (control_areset),
    .ap_start             (ap_start),
    .ap_continue          (ap_continue),
    .descriptor_valid     (descriptor_valid),
    .descriptor_base_addr (descriptor_base_addr),
    .descriptor_num_reads (descriptor_num_reads),
    .req_queue_busy       (req_busy),
    .resp_queue_busy      (resp_busy),
    .job_complete         (job_complete),
    .job_checksum         (job_checksum),
    .ap_ready             (ap_ready),
    .ap_idle              (ap_idle),
    .ap_done              (ap_done),
    .result_checksum      (result_checksum),
    .job_start            (job_start),
    .job_base_addr        (job_base_addr),
    .job_num_reads        (job_num_reads)
  );

  // ------------------------------------------------------------------------
  // Setup reads
  // ------------------------------------------------------------------------
  setup_request_gen gen0 (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .job_start      (job_start),
    .job_base_addr  (job_base_addr),
    .job_num_reads  (job_num_reads),
    .req_full       (req_full),
    .req_push       (req_push),
    .req_addr       (req_addr),
    .resp_empty     (resp_empty),
    .resp_pop       (resp_pop),
    .resp_data      (resp_data),
    .job_complete   (job_complete),
    .job_checksum   (job_checksum)
  );

  // ------------------------------------------------------------------------
  // Memory-side queues
  // ------------------------------------------------------------------------
  // Memory ready strobe pops the head
  sync_fifo #(
    .WIDTH (ADDR_W),
    .DEPTH (QUEUE_DEPTH)
  ) req_queue (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .wr_en          (req_push),
    .din            (req_addr),
    .rd_en          (mem_req_ready),
    .dout           (mem_req_addr),
    .full           (req_full),
    .empty          (req_empty),
    .busy           (req_busy)
  );

  // Full flag left open, generator credits bound the fill level
  sync_fifo #(
    .WIDTH (DATA_W),
    .DEPTH (QUEUE_DEPTH)
  ) resp_queue (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .wr_en          (mem_resp_valid),
    .din            (mem_resp_data),
    .rd_en          (resp_pop),
    .dout           (resp_data),
    .full           (),
    .empty          (resp_empty),
    .busy           (resp_busy)
  );

endmodule

`default_nettype wire

// ==== graph_kernel_asserts.sv ====
// Protocol checks on the graph kernel top level
// Host handshake rules and the memory request hold, bound into graph_kernel_top
`timescale 1ns/1ps
`default_nettype none

module graph_kernel_asserts (
  input logic                            ap_clk,
  input logic                            control_areset,
  input logic                            ap_ready,
  input logic                            ap_idle,
  input logic                            ap_done,
  input logic                            mem_req_valid,
  input logic                            mem_req_ready,
  input graph_kernel_pkg::addr_t         mem_req_addr,
  input graph_kernel_pkg::control_state_t ctl_state
);
  import graph_kernel_pkg::*;

  // Ready is a single-cycle pulse
  ready_pulse: assert property (@(posedge ap_clk) disable iff (control_areset)
    ap_ready |=> !ap_ready)
    else $error("ap_ready stayed high for more than one cycle");

  // Never done and idle at once
  done_idle_excl: assert property (@(posedge ap_clk) disable iff (control_areset)
    !(ap_done && ap_idle))
    else $error("ap_done and ap_idle high together");

  // Stalled head request held in place
  req_hold: assert property (@(posedge ap_clk) disable iff (control_areset)
    (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req_addr)))
    else $error("mem_req_addr changed while stalled");

  // Requests only pending while a job runs
  req_in_job: assert property (@(posedge ap_clk) disable iff (control_areset)
    mem_req_valid |-> (ctl_state == ctl_busy))
    else $error("memory request pending outside a running job");

endmodule

bind graph_kernel_top graph_kernel_asserts asserts0 (
  .ap_clk         (ap_clk),
  .control_areset (control_areset),
  .ap_ready       (ap_ready),
  .ap_idle        (ap_idle),
  .ap_done        (ap_done),
  .mem_req_valid  (mem_req_valid),
  .mem_req_ready  (mem_req_ready),
  .mem_req_addr   (mem_req_addr),
  .ctl_state      (control0.state)
);

`default_nettype wire

// ==== tb_graph_kernel.sv ====
// Testbench for the graph kernel front end
// Runs host jobs against a memory model with random stalls and latency,
// and checks request addresses and checksums against a reference
`timescale 1ns/1ps
`default_nettype none

module tb_graph_kernel;
  import graph_kernel_pkg::*;

  localparam int CLK_PERIOD    = 8;
  localparam int READY_TIMEOUT = 100;
  localparam int DONE_TIMEOUT  = 20000;
  localparam int IDLE_TIMEOUT  = 20;
  // Memory word for a line is its address with this mask applied
  localparam logic [31:0] RESP_MASK = 32'hA5A5_0000;

  logic      ap_clk;
  logic      control_areset;
  logic      ap_start;
  logic      ap_continue;
  logic      descriptor_valid;
  addr_t     descriptor_base_addr;
  count_t    descriptor_num_reads;
  logic      ap_ready;
  logic      ap_idle;
  logic      ap_done;
  checksum_t result_checksum;
  logic      mem_req_valid;
  addr_t     mem_req_addr;
  logic      mem_req_ready;
  logic      mem_resp_valid;
  data_t     mem_resp_data;

  integer seed = 32'h7642_1622;
  int     errors;
  int     checks;
  bit     timed_out;

  // Memory model state
  bit     long_stalls;
  int     stall_left;
  int     cycle;
  addr_t  req_log[$];
  addr_t  resp_addr_q[$];
  int     resp_due_q[$];

  graph_kernel_top dut0 (
    .ap_clk               (ap_clk),
    .control_areset       (control_areset),
    .ap_start             (ap_start),
    .ap_continue          (ap_continue),
    .descriptor_valid     (descriptor_valid),
    .descriptor_base_addr (descriptor_base_addr),
    .descriptor_num_reads (descriptor_num_reads),
    .ap_ready             (ap_ready),
    .ap_idle              (ap_idle),
    .ap_done              (ap_done),
    .result_checksum      (result_checksum),
    .mem_req_valid        (mem_req_valid),
    .mem_req_addr         (mem_req_addr),
    .mem_req_ready        (mem_req_ready),
    .mem_resp_valid       (mem_resp_valid),
    .mem_resp_data        (mem_resp_data)
  );

  initial begin
    ap_clk = 1'b0;
    forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
  end

  // ------------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------------
  // Sum of all line words of one job, wraps at 32 bits
  function automatic checksum_t expected_checksum(input addr_t base, input count_t count);
    checksum_t sum;
    addr_t     addr;
    sum  = '0;
    addr = base;
    for (int i = 0; i < int'(count); i++) begin
      sum  = sum + (addr ^ RESP_MASK);
      addr = addr + addr_t'(LINE_BYTES);
    end
    return sum;
  endfunction

  // ------------------------------------------------------------------------
  // Memory model
  // ------------------------------------------------------------------------
  initial begin : memory_model
    logic [31:0] rnd;
    mem_req_ready  = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_data  = '0;
    stall_left     = 0;
    cycle          = 0;
    forever begin
      @(negedge ap_clk);
      // Transfer happens at the coming edge
      if (mem_req_valid && mem_req_ready) begin
        rnd = $random(seed);
        req_log.push_back(mem_req_addr);
        resp_addr_q.push_back(mem_req_addr);
        resp_due_q.push_back(cycle + 1 + int'(rnd[19:16]));
      end
      @(posedge ap_clk);
      cycle++;
      #1;
      rnd = $random(seed);
      if (stall_left > 0) begin
        stall_left--;
        mem_req_ready = 1'b0;
      end else if (long_stalls && rnd[7:4] == 4'h0) begin
        // Long stall of 8 to 39 cycles
        stall_left    = 8 + int'(rnd[12:8]);
        mem_req_ready = 1'b0;
      end else begin
        mem_req_ready = rnd[0] | rnd[1];
      end
      // Responses leave in request order
      if (resp_due_q.size() > 0 && resp_due_q[0] <= cycle) begin
        mem_resp_valid = 1'b1;
        mem_resp_data  = resp_addr_q.pop_front() ^ RESP_MASK;
        void'(resp_due_q.pop_front());
      end else begin
        mem_resp_valid = 1'b0;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------------
  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // Drive point a little after the rising edge
  task automatic advance_cycle();
    @(posedge ap_clk);
    #1;
  endtask

  // Polls a flag at the falling edge, 0 ready, 1 done, 2 idle
  task automatic wait_level(input string name, input int sel, input int limit);
    int n;
    bit seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < limit) begin
      @(negedge ap_clk);
      n++;
      case (sel)
        0:       seen = ap_ready;
        1:       seen = ap_done;
        default: seen = ap_idle;
      endcase
    end
    if (!seen) begin
      timed_out = 1'b1;
      $display("Timeout at %0t, %s did not rise within %0d cycles", $time, name, limit);
    end
  endtask

  // One complete job from start to continue
  task automatic run_job(input addr_t base, input count_t num, input bit stalls);
    checksum_t   exp_sum;
    addr_t       exp_addr;
    logic [31:0] rnd;
    int          hold;
    exp_sum     = expected_checksum(base, num);
    long_stalls = stalls;
    req_log.delete();
    advance_cycle();
    ap_start = 1'b1;
    wait_level("ap_ready", 0, READY_TIMEOUT);
    if (timed_out) return;
    compare_flag("ap_idle", ap_idle, 1'b0);
    advance_cycle();
    ap_start             = 1'b0;
    descriptor_valid     = 1'b1;
    descriptor_base_addr = base;
    descriptor_num_reads = num;
    advance_cycle();
    descriptor_valid = 1'b0;
    wait_level("ap_done", 1, DONE_TIMEOUT);
    if (timed_out) return;
    compare_word("result_checksum", result_checksum, exp_sum);
    compare_word("request count", 32'(req_log.size()), 32'(num));
    // Line walk in issue order
    exp_addr = base;
    foreach (req_log[i]) begin
      compare_word("mem_req_addr", req_log[i], exp_addr);
      exp_addr = exp_addr + addr_t'(LINE_BYTES);
    end
    // Done must hold until continue
    rnd  = $random(seed);
    hold = 2 + int'(rnd[2:0]);
    repeat (hold) begin
      @(negedge ap_clk);
      compare_flag("ap_done", ap_done, 1'b1);
      compare_flag("ap_idle", ap_idle, 1'b0);
    end
    advance_cycle();
    ap_continue = 1'b1;
    advance_cycle();
    ap_continue = 1'b0;
    wait_level("ap_idle", 2, IDLE_TIMEOUT);
    if (timed_out) return;
    compare_flag("ap_done", ap_done, 1'b0);
    compare_word("response backlog", 32'(resp_addr_q.size()), 32'd0);
  endtask

  // ------------------------------------------------------------------------
  // Stimulus and final report
  // ------------------------------------------------------------------------
  initial begin : stimulus
    logic [31:0] rnd;
    errors               = 0;
    checks               = 0;
    timed_out            = 1'b0;
    long_stalls          = 1'b0;
    control_areset       = 1'b1;
    ap_start             = 1'b0;
    ap_continue          = 1'b0;
    descriptor_valid     = 1'b0;
    descriptor_base_addr = '0;
    descriptor_num_reads = '0;
    repeat (10) @(posedge ap_clk);
    #1;
    control_areset = 1'b0;
    // Quiet outputs through the queue init window
    repeat (20) begin
      @(negedge ap_clk);
      compare_flag("ap_idle", ap_idle, 1'b1);
      compare_flag("ap_ready", ap_ready, 1'b0);
      compare_flag("ap_done", ap_done, 1'b0);
      compare_flag("mem_req_valid", mem_req_valid, 1'b0);
    end
    run_job(32'h0001_0000, 8'd5, 1'b0);
    // More reads than queue depth under long stalls
    if (!timed_out) run_job(32'h2000_0040, 8'd40, 1'b1);
    if (!timed_out) run_job(32'h0000_3000, 8'd0, 1'b0);
    if (!timed_out) begin
      rnd = $random(seed);
      run_job({rnd[31:6], 6'b0}, count_t'(rnd[5:0]) + count_t'(1), 1'b1);
    end
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
graph_kernel_pkg.sv
sync_fifo.sv
kernel_control.sv
setup_request_gen.sv
graph_kernel_top.sv
graph_kernel_asserts.sv
tb_graph_kernel.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_graph_kernel
FILELIST  = project.f
OBJ_DIR   = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /$(PASS_MSG)/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
